/* csr_defs_pkg.sv */
`default_nettype none

package csr_defs_pkg;

    // datapath and address widths
    localparam int xlen       = 64;
    localparam int csr_addr_w = 12;

    // machine-mode csr addresses
    localparam logic [csr_addr_w-1:0] csr_mstatus = 12'h300;
    localparam logic [csr_addr_w-1:0] csr_mtvec   = 12'h305;
    localparam logic [csr_addr_w-1:0] csr_mepc    = 12'h341;
    localparam logic [csr_addr_w-1:0] csr_mcause  = 12'h342;

    // mstatus field positions
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    // mpp is two bits wide, starting here
    localparam int mstatus_mpp_lo   = 11;

    // only mie, mpie and mpp are implemented in mstatus
    localparam logic [xlen-1:0] mstatus_wmask =
        (64'd1 << mstatus_mie_bit) |
        (64'd1 << mstatus_mpie_bit) |
        (64'd3 << mstatus_mpp_lo);

    // direct mode only, so mtvec and mepc stay 4-byte aligned
    localparam logic [xlen-1:0] tvec_align_mask = ~64'd3;

endpackage

`default_nettype wire

/* csr_ops_pkg.sv */
`default_nettype none

package csr_ops_pkg;

    // encoded like funct3[1:0] of csrrw, csrrs and csrrc
    typedef enum logic [1:0] {
        op_rw = 2'd1,
        op_rs = 2'd2,
        op_rc = 2'd3
    } csr_op_t;

    // exception cause field width
    localparam int cause_w = 6;

    // trap sequencer states
    typedef enum logic [2:0] {
        idle      = 3'd0,
        wr_epc    = 3'd1,
        wr_cause  = 3'd2,
        wr_status = 3'd3,
        redirect  = 3'd4
    } trap_state_t;

endpackage

`default_nettype wire

/* csr_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_regs (
    input  logic                               clk,
    input  logic                               rst,

    // read port
    input  logic [csr_defs_pkg::csr_addr_w-1:0] raddr_i,
    output logic [csr_defs_pkg::xlen-1:0]       rdata_o,

    // write port
    input  logic                               wen_i,
    input  logic [csr_defs_pkg::csr_addr_w-1:0] waddr_i,
    input  logic [csr_defs_pkg::xlen-1:0]       wdata_i,

    // levels for the trap sequencer
    output logic [csr_defs_pkg::xlen-1:0]       mstatus_o,
    output logic [csr_defs_pkg::xlen-1:0]       mtvec_o,
    output logic [csr_defs_pkg::xlen-1:0]       mepc_o
);

    import csr_defs_pkg::*;

    logic [xlen-1:0] mstatus_q;
    logic [xlen-1:0] mtvec_q;
    logic [xlen-1:0] mepc_q;
    logic [xlen-1:0] mcause_q;

    // write port, fields masked on the way in
    always_ff @(posedge clk) begin
        if (!rst) begin
            mstatus_q <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (wen_i) begin
            case (waddr_i)
                csr_mstatus: begin
                    mstatus_q <= wdata_i & mstatus_wmask;
                end
                csr_mtvec: begin
                    mtvec_q <= wdata_i & tvec_align_mask;
                end
                csr_mepc: begin
                    mepc_q <= wdata_i & tvec_align_mask;
                end
                csr_mcause: begin
                    mcause_q <= wdata_i;
                end
                default: begin
                    // unknown address, write dropped
                end
            endcase
        end
    end

    // combinational read mux
    always_comb begin
        case (raddr_i)
            csr_mstatus: rdata_o = mstatus_q;
            csr_mtvec:   rdata_o = mtvec_q;
            csr_mepc:    rdata_o = mepc_q;
            csr_mcause:  rdata_o = mcause_q;
            default:     rdata_o = '0;
        endcase
    end

    assign mstatus_o = mstatus_q;
    assign mtvec_o   = mtvec_q;
    assign mepc_o    = mepc_q;

endmodule

`default_nettype wire

/* csr_op_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_op_unit (
    input  logic                                clk,
    input  logic                                rst,

    // instruction issue
    input  logic                                op_valid_i,
    input  csr_ops_pkg::csr_op_t                op_i,
    input  logic [csr_defs_pkg::csr_addr_w-1:0] op_addr_i,
    input  logic [csr_defs_pkg::xlen-1:0]       op_src_i,

    // csr read port
    output logic [csr_defs_pkg::csr_addr_w-1:0] raddr_o,
    input  logic [csr_defs_pkg::xlen-1:0]       rdata_i,

    // write request to the arbiter
    output logic                                wreq_o,
    output logic [csr_defs_pkg::csr_addr_w-1:0] waddr_o,
    output logic [csr_defs_pkg::xlen-1:0]       wdata_o,
    input  logic                                grant_i,

    // completion
    output logic                                done_o,
    output logic [csr_defs_pkg::xlen-1:0]       rd_o
);

    import csr_defs_pkg::*;
    import csr_ops_pkg::*;

    logic                  pend_q;
    logic                  done_q;
    csr_op_t               op_q;
    logic [csr_addr_w-1:0] addr_q;
    logic [xlen-1:0]       src_q;
    logic [xlen-1:0]       rd_q;

    csr_op_t               cur_op;
    logic [csr_addr_w-1:0] cur_addr;
    logic [xlen-1:0]       cur_src;
    logic [xlen-1:0]       new_val;

    // issue cycle uses the live inputs, later cycles the latched copy
    assign cur_op   = pend_q ? op_q   : op_i;
    assign cur_addr = pend_q ? addr_q : op_addr_i;
    assign cur_src  = pend_q ? src_q  : op_src_i;

    // read-modify-write on the value seen in the grant cycle
    always_comb begin
        case (cur_op)
            op_rw:   new_val = cur_src;
            op_rs:   new_val = rdata_i | cur_src;
            op_rc:   new_val = rdata_i & ~cur_src;
            default: new_val = rdata_i;
        endcase
    end

    assign wreq_o  = op_valid_i | pend_q;
    assign raddr_o = cur_addr;
    assign waddr_o = cur_addr;
    assign wdata_o = new_val;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pend_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            // keep requesting while the trap unit owns the port
            pend_q <= wreq_o & ~grant_i;
            done_q <= grant_i;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid_i) begin
            op_q   <= op_i;
            addr_q <= op_addr_i;
            src_q  <= op_src_i;
        end
        if (grant_i) begin
            rd_q <= rdata_i;
        end
    end

    assign done_o = done_q;
    assign rd_o   = rd_q;

endmodule

`default_nettype wire

/* trap_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module trap_unit (
    input  logic                                clk,
    input  logic                                rst,

    // trap and return requests
    input  logic                                trap_i,
    input  logic [csr_ops_pkg::cause_w-1:0]     cause_i,
    input  logic [csr_defs_pkg::xlen-1:0]       pc_i,
    input  logic                                mret_i,

    // current csr levels
    input  logic [csr_defs_pkg::xlen-1:0]       mstatus_i,
    input  logic [csr_defs_pkg::xlen-1:0]       mtvec_i,
    input  logic [csr_defs_pkg::xlen-1:0]       mepc_i,

    // write request, always wins arbitration
    output logic                                wreq_o,
    output logic [csr_defs_pkg::csr_addr_w-1:0] waddr_o,
    output logic [csr_defs_pkg::xlen-1:0]       wdata_o,

    output logic                                busy_o,
    output logic                                redirect_valid_o,
    output logic [csr_defs_pkg::xlen-1:0]       redirect_pc_o
);

    import csr_defs_pkg::*;
    import csr_ops_pkg::*;

    trap_state_t          state_q;
    trap_state_t          state_d;
    logic                 is_mret_q;
    logic [xlen-1:0]      epc_q;
    logic [cause_w-1:0]   cause_q;
    logic [xlen-1:0]      status_trap;
    logic [xlen-1:0]      status_mret;

    // trap entry: stack mie into mpie, disable, mpp = machine
    always_comb begin
        status_trap = mstatus_i;
        status_trap[mstatus_mpie_bit] = mstatus_i[mstatus_mie_bit];
        status_trap[mstatus_mie_bit]  = 1'b0;
        status_trap[mstatus_mpp_lo +: 2] = 2'b11;
    end

    // mret: restore mie, set mpie, mpp back to user
    always_comb begin
        status_mret = mstatus_i;
        status_mret[mstatus_mie_bit]  = mstatus_i[mstatus_mpie_bit];
        status_mret[mstatus_mpie_bit] = 1'b1;
        status_mret[mstatus_mpp_lo +: 2] = 2'b00;
    end

    always_comb begin
        case (state_q)
            idle: begin
                if (trap_i) begin
                    state_d = wr_epc;
                end else if (mret_i) begin
                    state_d = wr_status;
                end else begin
                    state_d = idle;
                end
            end
            wr_epc:    state_d = wr_cause;
            wr_cause:  state_d = wr_status;
            wr_status: state_d = redirect;
            default:   state_d = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q   <= idle;
            is_mret_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == idle && (trap_i || mret_i)) begin
                // trap wins if both show up together
                is_mret_q <= ~trap_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == idle && trap_i) begin
            epc_q   <= pc_i;
            cause_q <= cause_i;
        end
    end

    // one csr write per sequencer step
    always_comb begin
        wreq_o  = 1'b0;
        waddr_o = '0;
        wdata_o = '0;
        case (state_q)
            wr_epc: begin
                wreq_o  = 1'b1;
                waddr_o = csr_mepc;
                wdata_o = epc_q;
            end
            wr_cause: begin
                wreq_o  = 1'b1;
                waddr_o = csr_mcause;
                wdata_o = {{(xlen-cause_w){1'b0}}, cause_q};
            end
            wr_status: begin
                wreq_o  = 1'b1;
                waddr_o = csr_mstatus;
                wdata_o = is_mret_q ? status_mret : status_trap;
            end
            default: begin
            end
        endcase
    end

    assign busy_o           = (state_q != idle);
    assign redirect_valid_o = (state_q == redirect);
    assign redirect_pc_o    = is_mret_q ? mepc_i : mtvec_i;

endmodule

`default_nettype wire

/* csr_write_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_write_arbiter (
    // trap sequencer, highest priority
    input  logic                                trap_wreq_i,
    input  logic [csr_defs_pkg::csr_addr_w-1:0] trap_waddr_i,
    input  logic [csr_defs_pkg::xlen-1:0]       trap_wdata_i,

    // csr instruction unit
    input  logic                                op_wreq_i,
    input  logic [csr_defs_pkg::csr_addr_w-1:0] op_waddr_i,
    input  logic [csr_defs_pkg::xlen-1:0]       op_wdata_i,
    output logic                                op_grant_o,

    // shared csr write port
    output logic                                wen_o,
    output logic [csr_defs_pkg::csr_addr_w-1:0] waddr_o,
    output logic [csr_defs_pkg::xlen-1:0]       wdata_o
);

    // op unit only gets the port when the trap unit is quiet
    assign op_grant_o = op_wreq_i & ~trap_wreq_i;

    assign wen_o = trap_wreq_i | op_wreq_i;

    always_comb begin
        if (trap_wreq_i) begin
            waddr_o = trap_waddr_i;
            wdata_o = trap_wdata_i;
        end else begin
            waddr_o = op_waddr_i;
            wdata_o = op_wdata_i;
        end
    end

endmodule

`default_nettype wire

/* csr_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_subsystem (
    input  logic                                clk,
    input  logic                                rst,

    // csr instruction path
    input  logic                                op_valid_i,
    input  csr_ops_pkg::csr_op_t                op_i,
    input  logic [csr_defs_pkg::csr_addr_w-1:0] op_addr_i,
    input  logic [csr_defs_pkg::xlen-1:0]       op_src_i,
    output logic                                op_done_o,
    output logic [csr_defs_pkg::xlen-1:0]       op_rd_o,

    // trap path
    input  logic                                trap_i,
    input  logic [csr_ops_pkg::cause_w-1:0]     cause_i,
    input  logic [csr_defs_pkg::xlen-1:0]       pc_i,
    input  logic                                mret_i,
    output logic                                busy_o,
    output logic                                redirect_valid_o,
    output logic [csr_defs_pkg::xlen-1:0]       redirect_pc_o
);

    import csr_defs_pkg::*;

    // write requests
    logic                  op_wreq;
    logic [csr_addr_w-1:0] op_waddr;
    logic [xlen-1:0]       op_wdata;
    logic                  op_grant;
    logic                  trap_wreq;
    logic [csr_addr_w-1:0] trap_waddr;
    logic [xlen-1:0]       trap_wdata;

    // arbitrated write port
    logic                  csr_wen;
    logic [csr_addr_w-1:0] csr_waddr;
    logic [xlen-1:0]       csr_wdata;

    // read side
    logic [csr_addr_w-1:0] csr_raddr;
    logic [xlen-1:0]       csr_rdata;
    logic [xlen-1:0]       mstatus_q;
    logic [xlen-1:0]       mtvec_q;
    logic [xlen-1:0]       mepc_q;

    csr_regs u_csr_regs (
        .clk       (clk),
        .rst       (rst),
        .raddr_i   (csr_raddr),
        .rdata_o   (csr_rdata),
        .wen_i     (csr_wen),
        .waddr_i   (csr_waddr),
        .wdata_i   (csr_wdata),
        .mstatus_o (mstatus_q),
        .mtvec_o   (mtvec_q),
        .mepc_o    (mepc_q)
    );

    csr_op_unit u_csr_op_unit (
        .clk        (clk),
        .rst        (rst),
        .op_valid_i (op_valid_i),
        .op_i       (op_i),
        .op_addr_i  (op_addr_i),
        .op_src_i   (op_src_i),
        .raddr_o    (csr_raddr),
        .rdata_i    (csr_rdata),
        .wreq_o     (op_wreq),
        .waddr_o    (op_waddr),
        .wdata_o    (op_wdata),
        .grant_i    (op_grant),
        .done_o     (op_done_o),
        .rd_o       (op_rd_o)
    );

    trap_unit u_trap_unit (
        .clk              (clk),
        .rst              (rst),
        .trap_i           (trap_i),
        .cause_i          (cause_i),
        .pc_i             (pc_i),
        .mret_i           (mret_i),
        .mstatus_i        (mstatus_q),
        .mtvec_i          (mtvec_q),
        .mepc_i           (mepc_q),
        .wreq_o           (trap_wreq),
        .waddr_o          (trap_waddr),
        .wdata_o          (trap_wdata),
        .busy_o           (busy_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    csr_write_arbiter u_csr_write_arbiter (
        .trap_wreq_i  (trap_wreq),
        .trap_waddr_i (trap_waddr),
        .trap_wdata_i (trap_wdata),
        .op_wreq_i    (op_wreq),
        .op_waddr_i   (op_waddr),
        .op_wdata_i   (op_wdata),
        .op_grant_o   (op_grant),
        .wen_o        (csr_wen),
        .waddr_o      (csr_waddr),
        .wdata_o      (csr_wdata)
    );

endmodule

`default_nettype wire

/* csr_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_assertions (
    input logic clk,
    input logic rst,
    input logic op_grant_i,
    input logic trap_i,
    input logic busy_i,
    input logic redirect_valid_i
);

    logic trap_acc;
    logic trap_writing;

    // a trap is taken only from idle
    assign trap_acc = trap_i && !busy_i;

    // the sequencer writes in every busy cycle except the redirect
    assign trap_writing = busy_i && !redirect_valid_i;

    grant_excl: assert property (@(posedge clk) disable iff (!rst)
        trap_writing |-> !op_grant_i)
        else $error("op unit granted while the trap unit writes the port");

    // wr_epc, wr_cause, wr_status, redirect
    busy_held: assert property (@(posedge clk) disable iff (!rst)
        ($past(trap_acc, 1) || $past(trap_acc, 2) || $past(trap_acc, 3) ||
         $past(trap_acc, 4)) |-> busy_i)
        else $error("busy_o dropped within four cycles of a trap");

    busy_release: assert property (@(posedge clk) disable iff (!rst)
        $past(trap_acc, 5) |-> !busy_i)
        else $error("busy_o still high five cycles after a trap");

    redirect_pulse: assert property (@(posedge clk) disable iff (!rst)
        $past(redirect_valid_i) |-> !redirect_valid_i)
        else $error("redirect_valid_o longer than one cycle");

endmodule

bind csr_subsystem csr_assertions u_csr_assertions (
    .clk              (clk),
    .rst              (rst),
    .op_grant_i       (op_grant),
    .trap_i           (trap_i),
    .busy_i           (busy_o),
    .redirect_valid_i (redirect_valid_o)
);

`default_nettype wire

/* tb_csr_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_csr_subsystem;

    import csr_defs_pkg::*;
    import csr_ops_pkg::*;

    logic                  clk;
    logic                  rst;
    logic                  op_valid_i;
    csr_op_t               op_i;
    logic [csr_addr_w-1:0] op_addr_i;
    logic [xlen-1:0]       op_src_i;
    logic                  op_done_o;
    logic [xlen-1:0]       op_rd_o;
    logic                  trap_i;
    logic [cause_w-1:0]    cause_i;
    logic [xlen-1:0]       pc_i;
    logic                  mret_i;
    logic                  busy_o;
    logic                  redirect_valid_o;
    logic [xlen-1:0]       redirect_pc_o;

    // shadow copy of the four csrs
    logic [xlen-1:0]       sh_mstatus;
    logic [xlen-1:0]       sh_mtvec;
    logic [xlen-1:0]       sh_mepc;
    logic [xlen-1:0]       sh_mcause;

    logic [xlen-1:0]       exp_rd_q [$];
    logic [xlen-1:0]       exp_pc_q [$];
    logic [csr_addr_w-1:0] csr_list [4];
    string                 cur_test;
    int                    seed;
    int                    issued;
    int                    pass_cnt;
    int                    fail_cnt;
    int                    test_errs;

    csr_subsystem u_csr_subsystem (
        .clk              (clk),
        .rst              (rst),
        .op_valid_i       (op_valid_i),
        .op_i             (op_i),
        .op_addr_i        (op_addr_i),
        .op_src_i         (op_src_i),
        .op_done_o        (op_done_o),
        .op_rd_o          (op_rd_o),
        .trap_i           (trap_i),
        .cause_i          (cause_i),
        .pc_i             (pc_i),
        .mret_i           (mret_i),
        .busy_o           (busy_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    always #5 clk = ~clk;

    // expected old value for an op, expected redirect pc for trap or mret
    function automatic logic [xlen-1:0] ref_csr_step(
        input logic                  is_trap,
        input logic                  is_mret,
        input csr_op_t               op,
        input logic [csr_addr_w-1:0] addr,
        input logic [xlen-1:0]       src,
        input logic [cause_w-1:0]    cause,
        input logic [xlen-1:0]       pc
    );
        logic [xlen-1:0] old_val;
        logic [xlen-1:0] new_val;
        logic [xlen-1:0] st;
        st = sh_mstatus;
        if (is_trap) begin
            sh_mepc = pc & tvec_align_mask;
            sh_mcause = '0;
            sh_mcause[cause_w-1:0] = cause;
            st[mstatus_mpie_bit] = st[mstatus_mie_bit];
            st[mstatus_mie_bit] = 1'b0;
            st[mstatus_mpp_lo +: 2] = 2'b11;
            sh_mstatus = st & mstatus_wmask;
            return sh_mtvec;
        end
        if (is_mret) begin
            st[mstatus_mie_bit] = st[mstatus_mpie_bit];
            st[mstatus_mpie_bit] = 1'b1;
            st[mstatus_mpp_lo +: 2] = 2'b00;
            sh_mstatus = st & mstatus_wmask;
            return sh_mepc;
        end
        case (addr)
            csr_mstatus: old_val = sh_mstatus;
            csr_mtvec:   old_val = sh_mtvec;
            csr_mepc:    old_val = sh_mepc;
            csr_mcause:  old_val = sh_mcause;
            default:     old_val = '0;
        endcase
        case (op)
            op_rs:   new_val = old_val | src;
            op_rc:   new_val = old_val & ~src;
            default: new_val = src;
        endcase
        case (addr)
            csr_mstatus: sh_mstatus = new_val & mstatus_wmask;
            csr_mtvec:   sh_mtvec = new_val & tvec_align_mask;
            csr_mepc:    sh_mepc = new_val & tvec_align_mask;
            csr_mcause:  sh_mcause = new_val;
            default: begin
            end
        endcase
        return old_val;
    endfunction

    function automatic logic [xlen-1:0] random_word();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic flag_error();
        fail_cnt++;
        test_errs++;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d error(s)", cur_test, test_errs);
        end
    endtask

    task automatic issue_op(input csr_op_t op, input logic [csr_addr_w-1:0] addr,
                            input logic [xlen-1:0] src);
        exp_rd_q.push_back(ref_csr_step(1'b0, 1'b0, op, addr, src, '0, '0));
        issued++;
        op_valid_i = 1'b1;
        op_i = op;
        op_addr_i = addr;
        op_src_i = src;
        @(negedge clk);
        op_valid_i = 1'b0;
        while (!op_done_o) @(negedge clk);
        @(negedge clk);
    endtask

    // zero-operand csrrs, a pure read
    task automatic read_csr(input logic [csr_addr_w-1:0] addr);
        issue_op(op_rs, addr, '0);
    endtask

    task automatic take_trap(input logic [cause_w-1:0] cause, input logic [xlen-1:0] pc);
        while (busy_o) @(negedge clk);
        exp_pc_q.push_back(ref_csr_step(1'b1, 1'b0, op_rw, '0, '0, cause, pc));
        issued++;
        trap_i = 1'b1;
        cause_i = cause;
        pc_i = pc;
        @(negedge clk);
        trap_i = 1'b0;
        while (!redirect_valid_o) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic take_mret();
        while (busy_o) @(negedge clk);
        exp_pc_q.push_back(ref_csr_step(1'b0, 1'b1, op_rw, '0, '0, '0, '0));
        issued++;
        mret_i = 1'b1;
        @(negedge clk);
        mret_i = 1'b0;
        while (!redirect_valid_o) @(negedge clk);
        @(negedge clk);
    endtask

    // registered outputs, stable at the falling edge
    always @(negedge clk) begin : compare
        logic [xlen-1:0] exp;
        if (rst && op_done_o) begin
            if (exp_rd_q.size() == 0) begin
                $display("%s: op_done_o pulsed with no CSR operation outstanding", cur_test);
                flag_error();
            end else begin
                exp = exp_rd_q.pop_front();
                assert (op_rd_o == exp) pass_cnt++;
                else begin
                    $display("[ERROR] %s: op_rd_o expected %h, actual %h",
                             cur_test, exp, op_rd_o);
                    flag_error();
                end
            end
        end
        if (rst && redirect_valid_o) begin
            if (exp_pc_q.size() == 0) begin
                $display("%s: redirect_valid_o pulsed with no trap or mret pending", cur_test);
                flag_error();
            end else begin
                exp = exp_pc_q.pop_front();
                assert (redirect_pc_o == exp) pass_cnt++;
                else begin
                    $display("[ERROR] %s: redirect_pc_o expected %h, actual %h",
                             cur_test, exp, redirect_pc_o);
                    flag_error();
                end
            end
        end
    end

    // budget grows by 20 cycles with every issued operation
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= 10 + 20 * (issued + 1)) begin
            @(posedge clk);
            cycles++;
        end
        $display("watchdog: the DUT stopped responding, run aborted in test %s", cur_test);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : stimulus
        logic [31:0]     r;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] src;
        logic            saw_redirect;
        logic            saw_done;
        clk = 1'b0;
        rst = 1'b0;
        op_valid_i = 1'b0;
        op_i = op_rw;
        op_addr_i = '0;
        op_src_i = '0;
        trap_i = 1'b0;
        cause_i = '0;
        pc_i = '0;
        mret_i = 1'b0;
        sh_mstatus = '0;
        sh_mtvec = '0;
        sh_mepc = '0;
        sh_mcause = '0;
        seed = 46;
        issued = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        cur_test = "reset";
        csr_list = '{csr_mstatus, csr_mtvec, csr_mepc, csr_mcause};
        repeat (10) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);

        begin_test("write_read");
        foreach (csr_list[i]) begin
            issue_op(op_rw, csr_list[i], random_word());
            read_csr(csr_list[i]);
        end
        end_test();

        begin_test("set_clear");
        foreach (csr_list[i]) begin
            issue_op(op_rs, csr_list[i], random_word());
            read_csr(csr_list[i]);
            issue_op(op_rc, csr_list[i], random_word());
            read_csr(csr_list[i]);
        end
        end_test();

        begin_test("unknown_addr");
        issue_op(op_rw, 12'h7c0, random_word());
        read_csr(12'h7c0);
        foreach (csr_list[i]) read_csr(csr_list[i]);
        end_test();

        begin_test("trap_entry");
        // mie set so that the stacking into mpie is visible
        issue_op(op_rs, csr_mstatus, 64'h8);
        r = $random(seed);
        take_trap(r[cause_w-1:0], random_word());
        read_csr(csr_mepc);
        read_csr(csr_mcause);
        read_csr(csr_mstatus);
        end_test();

        begin_test("mret");
        take_mret();
        read_csr(csr_mstatus);
        end_test();

        begin_test("op_behind_trap");
        r = $random(seed);
        pc = random_word();
        src = random_word();
        exp_pc_q.push_back(ref_csr_step(1'b1, 1'b0, op_rw, '0, '0, r[cause_w-1:0], pc));
        exp_rd_q.push_back(ref_csr_step(1'b0, 1'b0, op_rw, csr_mepc, src, '0, '0));
        issued += 2;
        trap_i = 1'b1;
        cause_i = r[cause_w-1:0];
        pc_i = pc;
        @(negedge clk);
        trap_i = 1'b0;
        op_valid_i = 1'b1;
        op_i = op_rw;
        op_addr_i = csr_mepc;
        op_src_i = src;
        @(negedge clk);
        op_valid_i = 1'b0;
        saw_redirect = 1'b0;
        saw_done = 1'b0;
        while (!saw_done) begin
            // done checked first, so done alongside the redirect counts as early
            if (op_done_o) begin
                saw_done = 1'b1;
                assert (saw_redirect) pass_cnt++;
                else begin
                    $display("%s: op_done_o arrived before the trap writes finished", cur_test);
                    flag_error();
                end
            end
            if (redirect_valid_o) saw_redirect = 1'b1;
            if (!saw_done) @(negedge clk);
        end
        @(negedge clk);
        read_csr(csr_mepc);
        read_csr(csr_mstatus);
        end_test();

        if (exp_rd_q.size() != 0 || exp_pc_q.size() != 0) begin
            $display("some expected responses never arrived");
            fail_cnt++;
        end
        $display("checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
csr_defs_pkg.sv
csr_ops_pkg.sv
csr_regs.sv
csr_op_unit.sv
trap_unit.sv
csr_write_arbiter.sv
csr_subsystem.sv
csr_assertions.sv
tb_csr_subsystem.sv

/* Makefile */
TOP := tb_csr_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -f compile.f -o sim

run: compile
	@out="$$(./obj_dir/sim)"; echo "$$out"; \
	echo "$$out" | grep -q -F '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
